/* design/axiMemPkg.sv */
/*
  Shared sizes, channel payload structs and encodings for the AXI4 memory.
  Modules import this package inside their body and use scoped names in
  their port lists.
*/
`default_nettype none

package axiMemPkg;

  // bus and memory geometry
  localparam int DATA_BITS      = 32;
  localparam int STRB_BITS      = 4;   // bytes per bus word
  localparam int STRB_SHIFT     = 2;   // byte lane bits of an address
  localparam int ADDR_BITS      = 32;
  localparam int MEM_BYTES      = 1024;
  localparam int MEM_ADDR_BITS  = 10;
  localparam int WORD_ADDR_BITS = 8;
  localparam int ID_BITS        = 4;
  localparam int LEN_BITS       = 8;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10,   // stepped like INCR here
    RSVD  = 2'b11
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // AW and AR payload
  typedef struct packed {
    logic [ID_BITS-1:0]   id;
    logic [ADDR_BITS-1:0] addr;
    logic [LEN_BITS-1:0]  len;   // beats minus one
    logic [2:0]           size;
    burst_e               burst;
  } addrReq_t;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [STRB_BITS-1:0] strb;
    logic                 last;
  } wBeat_t;

  typedef struct packed {
    logic [ID_BITS-1:0] id;
    resp_e              resp;
  } bResp_t;

  typedef struct packed {
    logic [ID_BITS-1:0]   id;
    logic [DATA_BITS-1:0] data;
    resp_e                resp;
    logic                 last;
  } rBeat_t;

  // write port into the word RAM
  typedef struct packed {
    logic [WORD_ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0]      data;
    logic [STRB_BITS-1:0]      strb;
    logic                      en;
  } ramWrite_t;

endpackage

`default_nettype wire

/* design/burstTracker.sv */
/*
  Address and beat bookkeeping for one AXI burst.
  Load with the accepted request, pulse step once per beat; addr is the
  byte address of the current beat and isLast marks beat len.
*/
`timescale 1ns/100ps
`default_nettype none

module burstTracker (
  input  logic                                ACLK,
  input  logic                                ARESETn,
  input  logic                                load,
  input  axiMemPkg::addrReq_t                 req,
  input  logic                                step,
  output logic [axiMemPkg::MEM_ADDR_BITS-1:0] addr,
  output logic                                isLast
);
  import axiMemPkg::*;

  logic [2:0]               size;
  burst_e                   burst;
  logic [LEN_BITS-1:0]      len;
  logic [LEN_BITS-1:0]      beat;      // beats already stepped
  logic [MEM_ADDR_BITS-1:0] nextAddr;

  // FIXED holds, narrow beats add the size, full width goes to next word
  always_comb begin
    nextAddr = addr;
    if (burst != FIXED) begin
      if ((32'd1 << size) < STRB_BITS) begin
        nextAddr = addr + (MEM_ADDR_BITS'(1) << size);
      end else begin
        nextAddr = {addr[MEM_ADDR_BITS-1:STRB_SHIFT] + 1'b1, {STRB_SHIFT{1'b0}}};
      end
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      addr  <= '0;
      beat  <= '0;
      len   <= '0;
      size  <= '0;
      burst <= FIXED;
    end else if (load) begin
      addr  <= req.addr[MEM_ADDR_BITS-1:0];   // upper bits alias the 1 KB
      beat  <= '0;
      len   <= req.len;
      size  <= req.size;
      burst <= req.burst;
    end else if (step) begin
      addr <= nextAddr;
      beat <= beat + 1'b1;
    end
  end

  assign isLast = (beat == len);

endmodule

`default_nettype wire

/* design/dualPortRam.sv */
/*
  Word-wide RAM with one strobed write port and one registered read port.
  A read of the word being written in the same cycle returns the new
  bytes merged over the old ones.
*/
`timescale 1ns/100ps
`default_nettype none

module dualPortRam (
  input  logic                                 ACLK,
  input  logic                                 ARESETn,
  input  axiMemPkg::ramWrite_t                 ramWr,
  input  logic [axiMemPkg::WORD_ADDR_BITS-1:0] rdAddr,
  input  logic                                 rdEn,
  output logic [axiMemPkg::DATA_BITS-1:0]      rdData
);
  import axiMemPkg::*;

  logic [DATA_BITS-1:0] mem [MEM_BYTES/STRB_BITS];
  logic [DATA_BITS-1:0] merged;   // read word with write-first bypass

  always_comb begin
    merged = mem[rdAddr];
    if (ramWr.en && (ramWr.addr == rdAddr)) begin
      for (int i = 0; i < STRB_BITS; i++) begin
        if (ramWr.strb[i]) merged[8*i +: 8] = ramWr.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (ramWr.en) begin
      for (int i = 0; i < STRB_BITS; i++) begin
        if (ramWr.strb[i]) mem[ramWr.addr][8*i +: 8] <= ramWr.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      rdData <= '0;
    end else if (rdEn) begin
      rdData <= merged;   // holds between reads
    end
  end

endmodule

`default_nettype wire

/* design/axiMemWrite.sv */
/*
  Write side of the AXI4 memory: AW, W and B channels.
  Accepts one burst at a time and turns each W beat into a registered
  strobed write on the RAM port, then returns one B response.
*/
`timescale 1ns/100ps
`default_nettype none

module axiMemWrite (
  input  logic                 ACLK,
  input  logic                 ARESETn,
  input  axiMemPkg::addrReq_t  aw,
  input  logic                 awValid,
  output logic                 awReady,
  input  axiMemPkg::wBeat_t    w,
  input  logic                 wValid,
  output logic                 wReady,
  output axiMemPkg::bResp_t    b,
  output logic                 bValid,
  input  logic                 bReady,
  output axiMemPkg::ramWrite_t ramWr
);
  import axiMemPkg::*;

  typedef enum logic [1:0] {Idle, Data, Resp} wrState_e;

  wrState_e                  state;
  logic                      awFire;
  logic                      wFire;
  logic                      lastBeat;
  logic [MEM_ADDR_BITS-1:0]  beatAddr;
  logic                      wrEn;
  logic [WORD_ADDR_BITS-1:0] wrAddr;
  logic [DATA_BITS-1:0]      wrData;
  logic [STRB_BITS-1:0]      wrStrb;

  assign awFire = awValid && awReady;
  assign wFire  = wValid && wReady;   // wReady only high in Data

  burstTracker wrTracker (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .load    (awFire),
    .req     (aw),
    .step    (wFire),
    .addr    (beatAddr),
    .isLast  (lastBeat)
  );

  // ---------------------------------------------------------------------
  // channel FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state   <= Idle;
      awReady <= 1'b0;
      wReady  <= 1'b0;
      bValid  <= 1'b0;
      wrEn    <= 1'b0;
    end else begin
      wrEn <= wFire;
      case (state)
        Idle: begin
          if (awFire) begin
            awReady <= 1'b0;
            wReady  <= 1'b1;
            state   <= Data;
          end else begin
            awReady <= 1'b1;
          end
        end
        Data: begin
          // tracker decides the end, not WLAST
          if (wFire && lastBeat) begin
            wReady <= 1'b0;
            bValid <= 1'b1;
            state  <= Resp;
          end
        end
        Resp: begin
          if (bReady) begin
            bValid  <= 1'b0;
            awReady <= 1'b1;
            state   <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // beat and response payload
  always_ff @(posedge ACLK) begin
    if (awFire) b.id <= aw.id;
    if (wFire && lastBeat) b.resp <= w.last ? OKAY : SLVERR;   // missing WLAST
    if (wFire) begin
      wrAddr <= beatAddr[MEM_ADDR_BITS-1:STRB_SHIFT];
      wrData <= w.data;
      wrStrb <= w.strb;
    end
  end

  assign ramWr = '{addr: wrAddr, data: wrData, strb: wrStrb, en: wrEn};

endmodule

`default_nettype wire

/* design/axiMemRead.sv */
/*
  Read side of the AXI4 memory: AR and R channels.
  Issues one RAM read per cycle while a slot is free; a beat sits in the
  RAM output register or, when R stalls, in a skid register in front of it.
  At most two beats are in flight.
*/
`timescale 1ns/100ps
`default_nettype none

module axiMemRead (
  input  logic                                 ACLK,
  input  logic                                 ARESETn,
  input  axiMemPkg::addrReq_t                  ar,
  input  logic                                 arValid,
  output logic                                 arReady,
  output axiMemPkg::rBeat_t                    r,
  output logic                                 rValid,
  input  logic                                 rReady,
  output logic [axiMemPkg::WORD_ADDR_BITS-1:0] ramRdAddr,
  output logic                                 ramRdEn,
  input  logic [axiMemPkg::DATA_BITS-1:0]      ramRdData
);
  import axiMemPkg::*;

  typedef enum logic [1:0] {Idle, Burst, Drain} rdState_e;

  rdState_e                 state;
  logic                     arFire;
  logic                     rFire;
  logic                     issue;
  logic                     lastBeat;
  logic                     ramToSkid;
  logic [MEM_ADDR_BITS-1:0] beatAddr;
  logic [1:0]               inFlight;
  logic [ID_BITS-1:0]       rId;
  logic                     ramValid;    // RAM output holds an unsent beat
  logic                     ramLast;
  logic                     skidValid;   // older beat parked while R stalled
  logic                     skidLast;
  logic [DATA_BITS-1:0]     skidData;

  assign arFire   = arValid && arReady;
  assign inFlight = {1'b0, ramValid} + {1'b0, skidValid};

  // no read when both slots are full and nothing leaves this cycle
  assign issue     = (state == Burst) && !(inFlight == 2'd2 && !rReady);
  assign ramRdEn   = issue;
  assign ramRdAddr = beatAddr[MEM_ADDR_BITS-1:STRB_SHIFT];

  // RAM word about to be overwritten but not sent yet
  assign ramToSkid = issue && ramValid && (skidValid || !rReady);

  burstTracker rdTracker (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .load    (arFire),
    .req     (ar),
    .step    (issue),
    .addr    (beatAddr),
    .isLast  (lastBeat)
  );

  // ---------------------------------------------------------------------
  // output side, skid has priority since it holds the older beat
  // ---------------------------------------------------------------------
  assign rValid = ramValid || skidValid;
  assign rFire  = rValid && rReady;
  assign r = '{id:   rId,
               data: skidValid ? skidData : ramRdData,
               resp: OKAY,
               last: skidValid ? skidLast : ramLast};

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state     <= Idle;
      arReady   <= 1'b0;
      ramValid  <= 1'b0;
      skidValid <= 1'b0;
    end else begin
      if (issue) begin
        ramValid <= 1'b1;
      end else if (rFire && !skidValid) begin
        ramValid <= 1'b0;
      end

      if (ramToSkid) begin
        skidValid <= 1'b1;
      end else if (rFire && skidValid) begin
        skidValid <= 1'b0;
      end

      case (state)
        Idle: begin
          if (arFire) begin
            arReady <= 1'b0;
            state   <= Burst;
          end else begin
            arReady <= 1'b1;
          end
        end
        Burst: if (issue && lastBeat) state <= Drain;   // all reads issued
        Drain: begin
          if (rFire && r.last) begin
            arReady <= 1'b1;
            state   <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (arFire) rId <= ar.id;
    if (issue) ramLast <= lastBeat;   // follows the read into the RAM stage
    if (ramToSkid) begin
      skidData <= ramRdData;
      skidLast <= ramLast;
    end
  end

endmodule

`default_nettype wire

/* design/axiMem.sv */
/*
  1 KB on-chip memory behind an AXI4 burst slave port.
  Independent write and read engines share one dual-port RAM.
*/
`timescale 1ns/100ps
`default_nettype none

module axiMem (
  input  logic                ACLK,
  input  logic                ARESETn,
  input  axiMemPkg::addrReq_t aw,
  input  logic                awValid,
  output logic                awReady,
  input  axiMemPkg::wBeat_t   w,
  input  logic                wValid,
  output logic                wReady,
  output axiMemPkg::bResp_t   b,
  output logic                bValid,
  input  logic                bReady,
  input  axiMemPkg::addrReq_t ar,
  input  logic                arValid,
  output logic                arReady,
  output axiMemPkg::rBeat_t   r,
  output logic                rValid,
  input  logic                rReady
);
  import axiMemPkg::*;

  ramWrite_t                 ramWr;
  logic [WORD_ADDR_BITS-1:0] ramRdAddr;
  logic                      ramRdEn;
  logic [DATA_BITS-1:0]      ramRdData;

  axiMemWrite writeEngine (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .aw      (aw),
    .awValid (awValid),
    .awReady (awReady),
    .w       (w),
    .wValid  (wValid),
    .wReady  (wReady),
    .b       (b),
    .bValid  (bValid),
    .bReady  (bReady),
    .ramWr   (ramWr)
  );

  axiMemRead readEngine (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .ar        (ar),
    .arValid   (arValid),
    .arReady   (arReady),
    .r         (r),
    .rValid    (rValid),
    .rReady    (rReady),
    .ramRdAddr (ramRdAddr),
    .ramRdEn   (ramRdEn),
    .ramRdData (ramRdData)
  );

  dualPortRam ram (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .ramWr   (ramWr),
    .rdAddr  (ramRdAddr),
    .rdEn    (ramRdEn),
    .rdData  (ramRdData)
  );

endmodule

`default_nettype wire

/* tests/axiMem_assertions.sv */
/*
  Concurrent handshake checks for the AXI4 memory, bound into axiMem.
  Covers valid hold, R payload stability, B/W exclusion and arReady
  during a read burst.
*/
`timescale 1ns/100ps
`default_nettype none

module axiMemAssertions (
  input logic              ACLK,
  input logic              ARESETn,
  input logic              wReady,
  input logic              bValid,
  input logic              bReady,
  input logic              arValid,
  input logic              arReady,
  input axiMemPkg::rBeat_t r,
  input logic              rValid,
  input logic              rReady
);
  import axiMemPkg::*;

  logic rdBusy;   // AR taken, last R beat not sent yet

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      rdBusy <= 1'b0;
    end else if (arValid && arReady) begin
      rdBusy <= 1'b1;
    end else if (rValid && rReady && r.last) begin
      rdBusy <= 1'b0;
    end
  end

  bHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bValid && !bReady |=> bValid) else $error("bValid dropped before bReady");

  rHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rValid && !rReady |=> rValid) else $error("rValid dropped before rReady");

  rStable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rValid && !rReady |=> $stable(r)) else $error("r payload changed during a stall");

  wNotWithB: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(wReady && bValid)) else $error("wReady high while bValid is pending");

  arIdle: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rdBusy |-> !arReady) else $error("arReady high during a read burst");

endmodule

bind axiMem axiMemAssertions handshakeChecks (
  .ACLK    (ACLK),
  .ARESETn (ARESETn),
  .wReady  (wReady),
  .bValid  (bValid),
  .bReady  (bReady),
  .arValid (arValid),
  .arReady (arReady),
  .r       (r),
  .rValid  (rValid),
  .rReady  (rReady)
);

`default_nettype wire

/* tests/axiMemTb.sv */
/*
  Testbench for the AXI4 burst memory.
  Replays the write and read records of tests/axiMem_testdata.txt through
  the AXI channels under random rReady and bReady stalls. It checks B and R
  responses against the values in the file and ends with a one-line error count.
*/
`timescale 1ns/100ps
`default_nettype none

module axiMemTb;
  import axiMemPkg::*;

  localparam int MAX_WAIT = 1000;   // cycles allowed per handshake

  logic     ACLK;
  logic     ARESETn;
  addrReq_t aw;
  logic     awValid;
  logic     awReady;
  wBeat_t   w;
  logic     wValid;
  logic     wReady;
  bResp_t   b;
  logic     bValid;
  logic     bReady;
  addrReq_t ar;
  logic     arValid;
  logic     arReady;
  rBeat_t   r;
  logic     rValid;
  logic     rReady;

  int          fd;
  int          errors;
  int          checks;
  bit          aborted;       // a wait timed out or the file is bad
  logic [31:0] rngState;
  logic [31:0] beatData[$];
  logic [3:0]  beatStrb[$];

  axiMem axiMem_inst (.*);

  initial begin
    ACLK = 1'b0;
    forever #50 ACLK = ~ACLK;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic reportTimeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("ERROR: gave up waiting for %s after %0d cycles at time %0t",
             what, MAX_WAIT, $time);
  endtask

  // skips comments and blank lines, ok low at end of file
  task automatic nextLine(output bit ok, output string line);
    int n;
    ok = 1'b0;
    line = "";
    while (!ok && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#" && line[0] != "\n") ok = 1'b1;
    end
  endtask

  task automatic recordLine(output string line);
    bit ok;
    nextLine(ok, line);
    if (!ok && !aborted) begin
      errors++;
      aborted = 1'b1;
      $display("ERROR: data file ends in the middle of a record");
    end
  endtask

  // ------------------------------------------------------------------
  // one write burst: AW, len+1 W beats, then B
  // ------------------------------------------------------------------
  task automatic runWrite(input string header);
    logic [31:0] id, addr, len;
    logic [31:0] size, burst, sendLast;
    logic [31:0] d, s, expResp;
    addrReq_t    req;
    string       line;
    bit          got;
    int          n;
    void'($sscanf(header, "W %h %h %h %h %h %h", id, addr, len, size, burst, sendLast));
    req = '{id: id[3:0], addr: addr, len: len[7:0], size: size[2:0],
            burst: burst_e'(burst[1:0])};
    beatData.delete();
    beatStrb.delete();
    for (int i = 0; i <= int'(req.len); i++) begin
      recordLine(line);
      void'($sscanf(line, "%h %h", d, s));
      beatData.push_back(d);
      beatStrb.push_back(s[3:0]);
    end
    recordLine(line);
    void'($sscanf(line, "B %h", expResp));
    if (aborted) return;

    aw      <= req;
    awValid <= 1'b1;
    n = 0;
    do begin
      @(posedge ACLK);
      n++;
    end while (!awReady && n < MAX_WAIT);
    if (!awReady) begin
      reportTimeout("awReady");
      return;
    end
    awValid <= 1'b0;

    for (int i = 0; i <= int'(req.len); i++) begin
      w <= '{data: beatData[i], strb: beatStrb[i],
             last: sendLast[0] && (i == int'(req.len))};   // WLAST may be withheld
      wValid <= 1'b1;
      n = 0;
      do begin
        @(posedge ACLK);
        n++;
      end while (!wReady && n < MAX_WAIT);
      if (!wReady) begin
        reportTimeout("wReady");
        return;
      end
    end
    wValid <= 1'b0;

    // random bReady, so bValid has to hold for a while
    got = 1'b0;
    n = 0;
    do begin
      @(posedge ACLK);
      n++;
      got = bValid && bReady;
      rngState = xorshift(rngState);
      bReady <= |rngState[1:0];
    end while (!got && n < MAX_WAIT);
    if (!got) begin
      reportTimeout("the B response");
      return;
    end
    bReady <= 1'b0;
    checkValue("b.id", 32'(b.id), 32'(req.id));
    checkValue("b.resp", 32'(b.resp), expResp);
  endtask

  // ------------------------------------------------------------------
  // one read burst with random rReady
  // ------------------------------------------------------------------
  task automatic runRead(input string header);
    logic [31:0] id, addr, len;
    logic [31:0] size, burst, word;
    logic [31:0] expWords[$];
    addrReq_t    req;
    rBeat_t      beat;
    string       line;
    bit          got;
    int          n;
    void'($sscanf(header, "R %h %h %h %h %h", id, addr, len, size, burst));
    req = '{id: id[3:0], addr: addr, len: len[7:0], size: size[2:0],
            burst: burst_e'(burst[1:0])};
    for (int i = 0; i <= int'(req.len); i++) begin
      recordLine(line);
      void'($sscanf(line, "%h", word));
      expWords.push_back(word);
    end
    if (aborted) return;

    ar      <= req;
    arValid <= 1'b1;
    n = 0;
    do begin
      @(posedge ACLK);
      n++;
    end while (!arReady && n < MAX_WAIT);
    if (!arReady) begin
      reportTimeout("arReady");
      return;
    end
    arValid <= 1'b0;

    for (int i = 0; i <= int'(req.len); i++) begin
      got = 1'b0;
      n = 0;
      do begin
        @(posedge ACLK);
        n++;
        got  = rValid && rReady;
        beat = r;
        rngState = xorshift(rngState);
        rReady <= |rngState[1:0];   // roughly one stall in four
      end while (!got && n < MAX_WAIT);
      if (!got) begin
        reportTimeout("an R beat");
        return;
      end
      checkValue("r.data", beat.data, expWords[i]);
      checkValue("r.id", 32'(beat.id), 32'(req.id));
      checkValue("r.resp", 32'(beat.resp), 32'(OKAY));
      checkValue("r.last", 32'(beat.last), 32'(i == int'(req.len)));
    end

    // nothing may follow the last beat
    @(posedge ACLK);
    checkValue("rValid after last beat", 32'(rValid), 32'd0);
    rReady <= 1'b0;
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    bit    ok;
    bit    done;
    string line;
    errors   = 0;
    checks   = 0;
    aborted  = 1'b0;
    done     = 1'b0;
    rngState = 32'h9db14b0b;
    ARESETn <= 1'b0;
    aw      <= '0;
    awValid <= 1'b0;
    w       <= '0;
    wValid  <= 1'b0;
    bReady  <= 1'b0;
    ar      <= '0;
    arValid <= 1'b0;
    rReady  <= 1'b0;

    repeat (2) @(posedge ACLK);
    ARESETn <= 1'b1;

    fd = $fopen("tests/axiMem_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      aborted = 1'b1;
      $display("ERROR: cannot open tests/axiMem_testdata.txt");
    end

    while (!aborted && !done) begin
      nextLine(ok, line);
      if (!ok) begin
        done = 1'b1;
      end else if (line[0] == "W") begin
        runWrite(line);
      end else if (line[0] == "R") begin
        runRead(line);
      end else begin
        errors++;
        aborted = 1'b1;
        $display("ERROR: unknown record in data file: %s", line);
      end
    end
    if (fd != 0) $fclose(fd);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/axiMem_testdata.txt */
# W id addr len size burst wlast, then len+1 lines "data strb", then "B resp"
# R id addr len size burst, then len+1 expected words; all fields hex
# single beat write and read back
W 1 000 0 2 1 1
11223344 f
B 0
R 2 000 0 2 1
11223344
# four word INCR burst
W 3 010 3 2 1 1
a0a0a0a0 f
b1b1b1b1 f
c2c2c2c2 f
d3d3d3d3 f
B 0
R 4 010 3 2 1
a0a0a0a0
b1b1b1b1
c2c2c2c2
d3d3d3d3
# byte beats with one-hot strobes build one word
W 5 020 3 0 1 1
eeeeeeaa 1
eeeebbee 2
eecceeee 4
ddeeeeee 8
B 0
R 6 020 0 2 1
ddccbbaa
# FIXED burst keeps the last beat, word at 020 untouched
W 7 024 2 2 0 1
01010101 f
02020202 f
03030303 f
B 0
R 8 020 1 2 1
ddccbbaa
03030303
# final beat without WLAST
W 9 028 1 2 1 0
12345678 f
9abcdef0 f
B 2
R a 028 1 2 1
12345678
9abcdef0
# eight beat read across everything above
R b 010 7 2 1
a0a0a0a0
b1b1b1b1
c2c2c2c2
d3d3d3d3
ddccbbaa
03030303
12345678
9abcdef0

/* sim.f */
design/axiMemPkg.sv
design/burstTracker.sv
design/dualPortRam.sv
design/axiMemWrite.sv
design/axiMemRead.sv
design/axiMem.sv
tests/axiMem_assertions.sv
tests/axiMemTb.sv

/* Makefile */
# Verilator simulation of the AXI4 burst memory
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= axiMemTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation stopped early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
